/* verilog.f */
+incdir+sim
hw/dbg_bus_pkg.sv
hw/wb_ctrl_regs.sv
hw/wb_word_ram.sv
hw/wb_addr_decode.sv
hw/wb_cmd_master.sv
hw/dbg_bus_top.sv
sim/tb_dbg_bus.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_dbg_bus \
    -f verilog.f -o tb_dbg_bus_sim || { echo "Build failed"; exit 1; }
./obj_dir/tb_dbg_bus_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "No result in log"; exit 1; }
echo "Simulation passed"

/* sim/tb_dbg_tests.svh */
`default_nettype none

// Set address with echo check
task automatic addr_cmd(input string name, input logic [29:0] addr, input bit inc);
    rsp_word_t act;
    send_cmd(name, CMD_SUB_ADDR, {1'b0, inc, addr}, act);
    check_word(name, make_rsp(RSP_SUB_ADDR, {1'b0, inc, addr}), act);
endtask

task automatic read_check(input string name, input logic [31:0] data);
    rsp_word_t act;
    send_cmd(name, CMD_SUB_RD, 32'd0, act);
    check_word(name, make_rsp(RSP_SUB_DATA, data), act);
endtask

// Writes answer with a zero payload
task automatic write_check(input string name, input logic [31:0] data);
    rsp_word_t act;
    send_cmd(name, CMD_SUB_WR, data, act);
    check_word(name, make_rsp(RSP_SUB_ACK, 32'd0), act);
endtask

task automatic err_check(input string name, input logic [1:0] sub);
    rsp_word_t act;
    send_cmd(name, sub, 32'h0BAD_0BAD, act);
    check_word(name, make_rsp(RSP_SUB_SPECIAL, {RSP_SPC_BUS_ERR, 29'd0}), act);
endtask

// Reset word first, then silence
task automatic reset_word_test();
    int n;
    bit got;
    rsp_word_t act;
    got = 1'b0;
    n   = 0;
    act = '0;
    while (!got && n < WAIT_LIMIT) begin
        @(posedge i_clk);
        got = o_rsp_stb;
        act = o_rsp_word;
        n++;
    end
    if (!got) begin
        $display("reset_word: no reset response after reset was released");
        timeouts++;
    end
    check_word("reset_word", make_rsp(RSP_SUB_SPECIAL, {RSP_SPC_RESET, 29'd0}), act);
    repeat (8) @(posedge i_clk);
    if (rsp_count != 1) begin
        $display("MISMATCH reset_word_count: expected 1, actual %0d", rsp_count);
        mismatches++;
    end
endtask

// Bit 31 of the payload comes back cleared
task automatic addr_echo_test();
    rsp_word_t act;
    send_cmd("addr_echo_rel", CMD_SUB_ADDR, 32'hC000_0123, act);
    check_word("addr_echo_rel", make_rsp(RSP_SUB_ADDR, 32'h4000_0123), act);
    addr_cmd("addr_echo_plain", 30'h1000_0005, 1'b0);
endtask

task automatic reg_access_test();
    logic [31:0] val;
    addr_cmd("id_addr", {REGION_REGS, 26'd0, REG_ID}, 1'b0);
    read_check("id_read", REG_ID_VALUE);
    addr_cmd("scratch_addr", {REGION_REGS, 26'd0, REG_SCRATCH}, 1'b0);
    for (int i = 0; i < 3; i++) begin
        val = 32'h5C00_0000 + i;
        write_check($sformatf("scratch_write[%0d]", i), val);
        scratch_writes++;
        last_scratch = val;
        read_check($sformatf("scratch_read[%0d]", i), val);
    end
    addr_cmd("count_addr", {REGION_REGS, 26'd0, REG_WR_COUNT}, 1'b0);
    read_check("wr_count_read", scratch_writes);
endtask

task automatic ram_autoinc_test();
    logic [31:0] ram_copy [16];
    logic [29:0] base;
    base = {REGION_RAM, 28'h000_0040};
    addr_cmd("ram_base", base, 1'b1);
    for (int i = 0; i < 16; i++) begin
        ram_copy[i] = rand_word();
        write_check($sformatf("ram_write[%0d]", i), ram_copy[i]);
    end
    addr_cmd("ram_rebase", base, 1'b1);
    for (int i = 0; i < 16; i++) begin
        read_check($sformatf("ram_read[%0d]", i), ram_copy[i]);
    end
    // Address sits at base plus 16 now, marker must land there
    write_check("ram_marker_write", 32'h600D_0010);
    addr_cmd("ram_after", base + 30'd16, 1'b0);
    read_check("ram_marker_read", 32'h600D_0010);
    // Auto-increment off, same word again
    read_check("ram_marker_hold", 32'h600D_0010);
endtask

task automatic bus_error_test();
    addr_cmd("unmap_addr", {2'd2, 28'h000_0100}, 1'b1);
    err_check("unmap_read", CMD_SUB_RD);
    // Offset 3, next word up would be RAM and ack
    addr_cmd("off3_addr", 30'h0FFF_FFFF, 1'b1);
    err_check("off3_read", CMD_SUB_RD);
    err_check("off3_write", CMD_SUB_WR);
    // Failed ID write leaves the address on ID
    addr_cmd("id_wr_addr", {REGION_REGS, 26'd0, REG_ID}, 1'b1);
    err_check("id_write", CMD_SUB_WR);
    read_check("id_after_err", REG_ID_VALUE);
    // Clean ack moved it on to scratch
    read_check("scratch_after_err", last_scratch);
endtask

`default_nettype wire

/* sim/tb_dbg_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_bus import dbg_bus_pkg::*; ();

    // Cycle budget for every wait loop
    localparam int WAIT_LIMIT = 100;

    logic      i_clk;
    logic      i_reset;
    logic      i_cmd_stb;
    cmd_word_t i_cmd_word;
    logic      o_cmd_busy;
    logic      o_rsp_stb;
    rsp_word_t o_rsp_word;

    // Run bookkeeping
    int          mismatches = 0;
    int          timeouts   = 0;
    int          cmds_sent  = 0;
    int          rsp_count  = 0;
    logic [31:0] lfsr_state = 32'h903d_c646;

    // Scratch register model
    int          scratch_writes = 0;
    logic [31:0] last_scratch   = 32'd0;

    dbg_bus_top dut0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_cmd_stb  (i_cmd_stb),
        .i_cmd_word (i_cmd_word),
        .o_cmd_busy (o_cmd_busy),
        .o_rsp_stb  (o_rsp_stb),
        .o_rsp_word (o_rsp_word)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Counts every response strobe including the reset word
    always @(posedge i_clk) begin
        if (!i_reset && o_rsp_stb) begin
            rsp_count <= rsp_count + 1;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit with the new bit shifted in at the bottom
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic rsp_word_t make_rsp(input logic [1:0] sub, input logic [31:0] payload);
        rsp_word_t r;
        r.sub     = sub;
        r.payload = payload;
        return r;
    endfunction

    task automatic check_word(input string name, input rsp_word_t exp, input rsp_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    // Strobe one command, hold it until accepted, return its response
    task automatic send_cmd(input string name, input logic [1:0] sub,
                            input logic [31:0] payload, output rsp_word_t rsp);
        int n;
        bit flag;
        bit busy_low;
        rsp      = '0;
        flag     = 1'b0;
        busy_low = 1'b0;
        n        = 0;
        @(posedge i_clk);
        i_cmd_stb          <= 1'b1;
        i_cmd_word.sub     <= sub;
        i_cmd_word.payload <= payload;
        // Accepted on the first edge that sees busy low
        while (!flag && n < WAIT_LIMIT) begin
            @(posedge i_clk);
            flag = !o_cmd_busy;
            n++;
        end
        i_cmd_stb <= 1'b0;
        if (!flag) begin
            $display("%s: command was never accepted, busy stayed high", name);
            timeouts++;
        end else begin
            cmds_sent++;
            flag = 1'b0;
            n    = 0;
            // Strobe and word sampled at the edge closing their cycle
            while (!flag && n < WAIT_LIMIT) begin
                @(posedge i_clk);
                flag = o_rsp_stb;
                rsp  = o_rsp_word;
                n++;
                // Busy holds from acceptance through the response cycle
                if (o_cmd_busy !== 1'b1 && !busy_low) begin
                    $display("MISMATCH %s busy: expected 1, actual %b", name, o_cmd_busy);
                    mismatches++;
                    busy_low = 1'b1;
                end
            end
            if (!flag) begin
                $display("%s: no response arrived for the command", name);
                timeouts++;
            end
        end
    endtask

    `include "tb_dbg_tests.svh"

    initial begin
        i_reset    <= 1'b1;
        i_cmd_stb  <= 1'b0;
        i_cmd_word <= '0;
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
        reset_word_test();
        addr_echo_test();
        reg_access_test();
        ram_autoinc_test();
        bus_error_test();
        // Let the response counter settle
        repeat (2) @(posedge i_clk);
        // One response per command plus the reset word
        if (rsp_count != cmds_sent + 1) begin
            $display("MISMATCH rsp_count: expected %0d, actual %0d", cmds_sent + 1, rsp_count);
            mismatches++;
        end
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/dbg_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_top import dbg_bus_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_cmd_stb,
    input  cmd_word_t i_cmd_word,
    output logic      o_cmd_busy,
    output logic      o_rsp_stb,
    output rsp_word_t o_rsp_word
);

    // Master to decoder
    wb_req_t m_req;
    wb_rsp_t m_rsp;

    // Decoder to slaves
    wb_req_t regs_req;
    wb_rsp_t regs_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;

    wb_cmd_master u_master (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_cmd_stb  (i_cmd_stb),
        .i_cmd_word (i_cmd_word),
        .o_cmd_busy (o_cmd_busy),
        .o_rsp_stb  (o_rsp_stb),
        .o_rsp_word (o_rsp_word),
        .i_wb       (m_rsp),
        .o_wb       (m_req)
    );

    wb_addr_decode u_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_m_req    (m_req),
        .o_m_rsp    (m_rsp),
        .o_regs_req (regs_req),
        .i_regs_rsp (regs_rsp),
        .o_ram_req  (ram_req),
        .i_ram_rsp  (ram_rsp)
    );

    // Region 0
    wb_ctrl_regs u_regs (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (regs_req),
        .o_rsp   (regs_rsp)
    );

    // Region 1, contents survive reset
    wb_word_ram u_ram (
        .i_clk (i_clk),
        .i_req (ram_req),
        .o_rsp (ram_rsp)
    );

endmodule

`default_nettype wire

/* hw/wb_cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_cmd_master import dbg_bus_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    // Command channel from the host decoder
    input  logic      i_cmd_stb,
    input  cmd_word_t i_cmd_word,
    output logic      o_cmd_busy,
    // Response channel, no back-pressure
    output logic      o_rsp_stb,
    output rsp_word_t o_rsp_word,
    // Bus master port
    input  wb_rsp_t   i_wb,
    output wb_req_t   o_wb
);

    // Control state
    logic        busy_r;
    logic        rst_pend;
    logic        rsp_stb_r;
    logic        wb_cyc;
    logic        wb_stb;
    logic [29:0] addr_r;
    logic        inc_r;

    // Payload registers
    logic        wb_we;
    logic [31:0] wb_data;
    rsp_word_t   rsp_word_r;

    // Command decode
    logic        cmd_accept;
    logic        cmd_takes;
    logic        cmd_is_bus;
    logic        cmd_is_addr;
    logic        bus_done;

    // No acceptance while the reset word is still owed
    assign cmd_accept  = i_cmd_stb && !busy_r && !rst_pend;
    assign cmd_takes   = cmd_accept && (i_cmd_word.sub != CMD_SUB_SPECIAL);
    assign cmd_is_bus  = cmd_accept &&
                         ((i_cmd_word.sub == CMD_SUB_RD) || (i_cmd_word.sub == CMD_SUB_WR));
    assign cmd_is_addr = cmd_accept && (i_cmd_word.sub == CMD_SUB_ADDR);

    // End of the bus cycle, either way
    assign bus_done = wb_cyc && (i_wb.ack || i_wb.err);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy_r    <= 1'b0;
            rst_pend  <= 1'b1;
            rsp_stb_r <= 1'b0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            addr_r    <= '0;
            inc_r     <= 1'b0;
        end else begin
            // Strobe is a single-cycle pulse unless set below
            rsp_stb_r <= 1'b0;
            // Busy ends once the response cycle is over
            if (rsp_stb_r) begin
                busy_r <= 1'b0;
            end
            if (rst_pend) begin
                // Reset word goes out first, busy covers its cycle
                rst_pend  <= 1'b0;
                rsp_stb_r <= 1'b1;
                busy_r    <= 1'b1;
            end else if (cmd_takes) begin
                busy_r <= 1'b1;
            end
            // Set address, echo in the next cycle
            if (cmd_is_addr) begin
                addr_r    <= i_cmd_word.payload[29:0];
                inc_r     <= i_cmd_word.payload[30];
                rsp_stb_r <= 1'b1;
            end
            // Start of a read or write cycle
            if (cmd_is_bus) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end
            // Hold strobe under stall
            if (wb_stb && !i_wb.stall) begin
                wb_stb <= 1'b0;
            end
            if (bus_done) begin
                wb_cyc    <= 1'b0;
                wb_stb    <= 1'b0;
                rsp_stb_r <= 1'b1;
                // Only a clean ack moves the address on
                if (inc_r && i_wb.ack && !i_wb.err) begin
                    addr_r <= addr_r + 30'd1;
                end
            end
        end
    end

    // Latched write data, direction and the outgoing response word
    always_ff @(posedge i_clk) begin
        if (cmd_is_bus) begin
            wb_we   <= (i_cmd_word.sub == CMD_SUB_WR);
            wb_data <= i_cmd_word.payload;
        end
        if (rst_pend) begin
            rsp_word_r.sub     <= RSP_SUB_SPECIAL;
            rsp_word_r.payload <= {RSP_SPC_RESET, 29'd0};
        end else if (cmd_is_addr) begin
            // Flag in bit 30, address below, bit 31 clear
            rsp_word_r.sub     <= RSP_SUB_ADDR;
            rsp_word_r.payload <= {1'b0, i_cmd_word.payload[30:0]};
        end else if (bus_done) begin
            if (i_wb.err) begin
                rsp_word_r.sub     <= RSP_SUB_SPECIAL;
                rsp_word_r.payload <= {RSP_SPC_BUS_ERR, 29'd0};
            end else if (wb_we) begin
                rsp_word_r.sub     <= RSP_SUB_ACK;
                rsp_word_r.payload <= 32'd0;
            end else begin
                rsp_word_r.sub     <= RSP_SUB_DATA;
                rsp_word_r.payload <= i_wb.data;
            end
        end
    end

    // Full-word access only, no byte selects on this bus
    always_comb begin
        o_wb.cyc  = wb_cyc;
        o_wb.stb  = wb_stb;
        o_wb.we   = wb_we;
        o_wb.addr = addr_r;
        o_wb.data = wb_data;
    end

    assign o_cmd_busy = busy_r;
    assign o_rsp_stb  = rsp_stb_r;
    assign o_rsp_word = rsp_word_r;

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        wb_stb |-> wb_cyc);

    a_rsp_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        rsp_stb_r |=> !rsp_stb_r);

    // One command in flight
    a_no_accept_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        cmd_accept |-> !wb_cyc);

endmodule

`default_nettype wire

/* hw/wb_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode import dbg_bus_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    // Master side
    input  wb_req_t i_m_req,
    output wb_rsp_t o_m_rsp,
    // Register block
    output wb_req_t o_regs_req,
    input  wb_rsp_t i_regs_rsp,
    // Word RAM
    output wb_req_t o_ram_req,
    input  wb_rsp_t i_ram_rsp
);

    logic [1:0] region;
    logic       sel_regs;
    logic       sel_ram;
    logic       unmapped;
    logic       unmap_err_r;

    // Region from the top address bits
    assign region   = i_m_req.addr[29:28];
    assign sel_regs = (region == REGION_REGS);
    assign sel_ram  = (region == REGION_RAM);
    assign unmapped = !sel_regs && !sel_ram;

    // Same request to both, strobe only to the selected slave
    always_comb begin
        o_regs_req     = i_m_req;
        o_regs_req.stb = i_m_req.stb && sel_regs;
        o_ram_req      = i_m_req;
        o_ram_req.stb  = i_m_req.stb && sel_ram;
    end

    // Local error, one cycle after an unmapped strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            unmap_err_r <= 1'b0;
        end else begin
            unmap_err_r <= i_m_req.cyc && i_m_req.stb && unmapped;
        end
    end

    // Reply from the selected slave only
    always_comb begin
        o_m_rsp.stall = 1'b0;
        o_m_rsp.ack   = 1'b0;
        o_m_rsp.err   = unmap_err_r;
        o_m_rsp.data  = 32'd0;
        if (sel_regs) begin
            o_m_rsp.stall = i_regs_rsp.stall;
            o_m_rsp.ack   = i_regs_rsp.ack;
            o_m_rsp.err   = i_regs_rsp.err;
            o_m_rsp.data  = i_regs_rsp.data;
        end else if (sel_ram) begin
            o_m_rsp.stall = i_ram_rsp.stall;
            o_m_rsp.ack   = i_ram_rsp.ack;
            o_m_rsp.err   = i_ram_rsp.err;
            o_m_rsp.data  = i_ram_rsp.data;
        end
    end

    // Strobe gating keeps the slaves from answering together
    a_single_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_regs_rsp.ack && i_ram_rsp.ack));

endmodule

`default_nettype wire

/* hw/wb_word_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_word_ram import dbg_bus_pkg::*; (
    input  logic    i_clk,
    input  wb_req_t i_req,
    output wb_rsp_t o_rsp
);

    // Word storage
    logic [31:0] mem [RAM_DEPTH];

    logic              req_hit;
    logic              wr_en;
    logic [RAM_AW-1:0] idx;
    logic              ack_r;
    logic [31:0]       rdata_r;

    assign req_hit = i_req.cyc && i_req.stb;
    assign wr_en   = req_hit && i_req.we;

    // Low address bits index the array, region bits ignored here
    assign idx = i_req.addr[RAM_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[idx] <= i_req.data;
        end
    end

    // Read data, old contents on a write
    always_ff @(posedge i_clk) begin
        if (req_hit) begin
            rdata_r <= mem[idx];
        end
    end

    // Ack one cycle after each strobe
    always_ff @(posedge i_clk) begin
        ack_r <= req_hit;
    end

    // Never stalls, never errors
    always_comb begin
        o_rsp.stall = 1'b0;
        o_rsp.ack   = ack_r;
        o_rsp.err   = 1'b0;
        o_rsp.data  = rdata_r;
    end

endmodule

`default_nettype wire

/* hw/wb_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ctrl_regs import dbg_bus_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    input  wb_req_t i_req,
    output wb_rsp_t o_rsp
);

    logic        req_hit;
    logic        stall;

    // Decode stage, valid in the second strobe cycle
    logic        dec_valid;
    logic [1:0]  dec_off;
    logic        dec_wr_scratch;
    logic        dec_bad;

    // Reply and register state
    logic        ack_r;
    logic        err_r;
    logic [31:0] rdata_r;
    logic [31:0] scratch_r;
    logic [31:0] wr_count_r;

    assign req_hit = i_req.cyc && i_req.stb;

    // Stall while the offset decode is being registered
    assign stall = req_hit && !dec_valid;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            dec_valid  <= 1'b0;
            ack_r      <= 1'b0;
            err_r      <= 1'b0;
            scratch_r  <= 32'd0;
            wr_count_r <= 32'd0;
        end else begin
            ack_r <= 1'b0;
            err_r <= 1'b0;
            if (stall) begin
                dec_valid <= 1'b1;
            end else if (req_hit) begin
                // Transfer taken, answer in the next cycle
                dec_valid <= 1'b0;
                ack_r     <= !dec_bad;
                err_r     <= dec_bad;
                if (dec_wr_scratch) begin
                    scratch_r  <= i_req.data;
                    wr_count_r <= wr_count_r + 32'd1;
                end
            end else begin
                // Strobe withdrawn, drop stale decode
                dec_valid <= 1'b0;
            end
        end
    end

    // Offset decode, first strobe cycle
    always_ff @(posedge i_clk) begin
        if (stall) begin
            dec_off        <= i_req.addr[1:0];
            dec_wr_scratch <= i_req.we && (i_req.addr[1:0] == REG_SCRATCH);
            // Offset 3, or a write to a read-only register
            dec_bad        <= (i_req.addr[1:0] == 2'd3) ||
                              (i_req.we && (i_req.addr[1:0] != REG_SCRATCH));
        end
    end

    // Read mux off the registered offset
    always_ff @(posedge i_clk) begin
        if (req_hit && !stall) begin
            case (dec_off)
                REG_ID:       rdata_r <= REG_ID_VALUE;
                REG_SCRATCH:  rdata_r <= scratch_r;
                REG_WR_COUNT: rdata_r <= wr_count_r;
                default:      rdata_r <= 32'd0;
            endcase
        end
    end

    always_comb begin
        o_rsp.stall = stall;
        o_rsp.ack   = ack_r;
        o_rsp.err   = err_r;
        o_rsp.data  = rdata_r;
    end

    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_rsp.ack && o_rsp.err));

endmodule

`default_nettype wire

/* hw/dbg_bus_pkg.sv */
`default_nettype none

package dbg_bus_pkg;

    // Command sub-codes in bits 33:32 of a command word
    localparam logic [1:0] CMD_SUB_RD      = 2'd0;
    localparam logic [1:0] CMD_SUB_WR      = 2'd1;
    localparam logic [1:0] CMD_SUB_ADDR    = 2'd2;
    // Reserved, dropped by the master
    localparam logic [1:0] CMD_SUB_SPECIAL = 2'd3;

    // Response sub-codes
    localparam logic [1:0] RSP_SUB_DATA    = 2'd0;
    localparam logic [1:0] RSP_SUB_ACK     = 2'd1;
    localparam logic [1:0] RSP_SUB_ADDR    = 2'd2;
    localparam logic [1:0] RSP_SUB_SPECIAL = 2'd3;

    // Special codes, carried in payload bits 31:29
    localparam logic [2:0] RSP_SPC_RESET   = 3'd0;
    localparam logic [2:0] RSP_SPC_BUS_ERR = 3'd1;

    // Region select from word address bits 29:28
    localparam logic [1:0] REGION_REGS = 2'd0;
    localparam logic [1:0] REGION_RAM  = 2'd1;

    // Word RAM geometry
    localparam int RAM_DEPTH = 256;
    localparam int RAM_AW    = 8;

    // Register block contents and offsets
    localparam logic [31:0] REG_ID_VALUE = 32'hD1B0_5001;
    localparam logic [1:0]  REG_ID       = 2'd0;
    localparam logic [1:0]  REG_SCRATCH  = 2'd1;
    localparam logic [1:0]  REG_WR_COUNT = 2'd2;

    // Host link words, 34 bits each
    typedef struct packed {
        logic [1:0]  sub;
        logic [31:0] payload;
    } cmd_word_t;

    typedef struct packed {
        logic [1:0]  sub;
        logic [31:0] payload;
    } rsp_word_t;

    // Bus request, master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [29:0] addr;
        logic [31:0] data;
    } wb_req_t;

    // Bus reply, slave side
    typedef struct packed {
        logic        stall;
        logic        ack;
        logic        err;
        logic [31:0] data;
    } wb_rsp_t;

endpackage

`default_nettype wire
